// File: verilog/hd44780_pkg.sv
// shared constants and state types for the hd44780 exerciser
// timing is in clock ticks, one set for both sim and build
// modules refer to everything here as hd44780_pkg::name

package hd44780_pkg;

    // ************************************************************
    // nybble sender timing
    // ************************************************************
    localparam int NYB_COUNT_BITS = 6;                         // must hold TICKS_TCYCE

    localparam logic [NYB_COUNT_BITS-1:0] TICKS_TAS   = 6'd3;  // data/rs setup before e rises
    localparam logic [NYB_COUNT_BITS-1:0] TICKS_PWEH  = 6'd22; // e high width
    localparam logic [NYB_COUNT_BITS-1:0] TICKS_TCYCE = 6'd48; // e rise to end of cycle

    // ************************************************************
    // alive leds
    // ************************************************************
    localparam int ALIVE_BITS = 8;      // sim scale, top 4 bits drive the leds
    localparam int PWM_BITS   = 3;      // rgb lit 1 cycle in 2^PWM_BITS

    // ************************************************************
    // message table
    // ************************************************************
    localparam int MSG_LEN      = 4;
    localparam int MSG_IDX_BITS = 2;

    // entry 0 is the rightmost byte
    localparam logic [MSG_LEN-1:0][7:0] MSG_BYTE = {
        8'h47,      // 'G', data
        8'h01,      // clear display
        8'h0C,      // display on, no cursor
        8'h28       // function set, 4 bit, 2 lines
    };

    // register select per entry, only the last one is data
    localparam logic [MSG_LEN-1:0] MSG_RS = 4'b1000;

    // ************************************************************
    // state machines
    // ************************************************************
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_WAIT,
        SEQ_DONE
    } seq_state_t;

    typedef enum logic [2:0] {
        BYTE_IDLE,
        BYTE_HIGH,
        BYTE_WAIT_HIGH,
        BYTE_LOW,
        BYTE_WAIT_LOW
    } byte_state_t;

    typedef enum logic [1:0] {
        NYB_IDLE,
        NYB_SETUP,
        NYB_E_HIGH,
        NYB_E_LOW
    } nyb_state_t;

endpackage

// File: verilog/hd44780_alive.sv
// arming and alive display
// the first button press arms the rest of the design and fires the analyzer strobe,
// a free running counter blinks the external leds and the dimmed rgb leds

`timescale 1ns/10ps

module hd44780_alive (
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_button_n,      // active low, from the pin
    output logic       o_armed,
    output logic       o_logan_strobe,  // logic analyzer trigger
    output logic [3:0] o_led,           // external leds, active low
    output logic       o_led_r,
    output logic       o_led_g,
    output logic       o_led_b
);

    logic                               btn_meta;   // first sync flop
    logic                               btn_sync;   // second sync flop
    logic                               armed_q;
    logic [hd44780_pkg::ALIVE_BITS-1:0] blink_cnt;
    logic [hd44780_pkg::PWM_BITS-1:0]   pwm_cnt;
    logic                               pwm_on;

    // ************************************************************
    // button sync and arm latch
    // ************************************************************
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            btn_meta <= 1'b1;                   // released
            btn_sync <= 1'b1;
            armed_q  <= 1'b0;
        end else begin
            btn_meta <= i_button_n;
            btn_sync <= btn_meta;
            armed_q  <= armed_q | ~btn_sync;    // sticky, no debounce needed
        end
    end

    assign o_armed        = armed_q;
    assign o_logan_strobe = armed_q;            // analyzer waits for this rising edge

    // ************************************************************
    // blink and dimming counters
    // ************************************************************
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            blink_cnt <= '0;
            pwm_cnt   <= '0;
        end else begin
            blink_cnt <= blink_cnt + 1'b1;      // free running
            pwm_cnt   <= pwm_cnt + 1'b1;
        end
    end

    assign pwm_on = &pwm_cnt;   // one cycle in eight

    // leds registered, external ones dark until armed
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_led   <= 4'hF;
            o_led_r <= 1'b0;
            o_led_g <= 1'b0;
            o_led_b <= 1'b0;
        end else begin
            if (armed_q) begin
                o_led <= {~blink_cnt[hd44780_pkg::ALIVE_BITS-4],
                           blink_cnt[hd44780_pkg::ALIVE_BITS-3],
                          ~blink_cnt[hd44780_pkg::ALIVE_BITS-2],
                           blink_cnt[hd44780_pkg::ALIVE_BITS-1]};
            end else begin
                o_led <= 4'hF;                  // all off
            end
            o_led_r <= pwm_on & ~blink_cnt[hd44780_pkg::ALIVE_BITS-2];
            o_led_g <= pwm_on & ~blink_cnt[hd44780_pkg::ALIVE_BITS-1];
            o_led_b <= pwm_on &  blink_cnt[hd44780_pkg::ALIVE_BITS-1]; // opposite phase to green
        end
    end

endmodule

// File: verilog/hd44780_msg_seq.sv
// message sequencer
// walks the fixed message table once after arming and hands each byte
// to the byte sender, then parks in SEQ_DONE until reset

`timescale 1ns/10ps

module hd44780_msg_seq (
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_armed,
    input  logic       i_byte_busy,
    output logic       o_byte_stb,      // one cycle pulse
    output logic [7:0] o_byte_data,
    output logic       o_byte_rs
);

    hd44780_pkg::seq_state_t              state;
    logic [hd44780_pkg::MSG_IDX_BITS-1:0] idx;      // table entry being sent

    // ************************************************************
    // sequencer fsm
    // ************************************************************
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= hd44780_pkg::SEQ_IDLE;
            idx   <= '0;
        end else if (!i_armed) begin
            state <= hd44780_pkg::SEQ_IDLE;     // hold until the button arms us
            idx   <= '0;
        end else begin
            case (state)
                hd44780_pkg::SEQ_IDLE: begin
                    state <= hd44780_pkg::SEQ_LOAD;
                end

                hd44780_pkg::SEQ_LOAD: begin
                    // strobe goes out this cycle, byte sender is idle here
                    state <= hd44780_pkg::SEQ_WAIT;
                end

                hd44780_pkg::SEQ_WAIT: begin
                    if (!i_byte_busy) begin
                        if (int'(idx) == hd44780_pkg::MSG_LEN - 1) begin
                            state <= hd44780_pkg::SEQ_DONE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= hd44780_pkg::SEQ_LOAD;
                        end
                    end
                end

                hd44780_pkg::SEQ_DONE: begin
                    state <= hd44780_pkg::SEQ_DONE;     // message sent, stay put
                end

                default: begin
                    state <= hd44780_pkg::SEQ_DONE;
                end
            endcase
        end
    end

    // table lookup, valid in the strobe cycle
    assign o_byte_stb  = (state == hd44780_pkg::SEQ_LOAD);
    assign o_byte_data = hd44780_pkg::MSG_BYTE[idx];
    assign o_byte_rs   = hd44780_pkg::MSG_RS[idx];

endmodule

// File: verilog/hd44780_byte_sender.sv
// byte sender
// takes one byte plus register select on a strobe and sends it as
// two nybble transfers, high nybble first, busy across both

`timescale 1ns/10ps

module hd44780_byte_sender (
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_armed,
    // byte side
    input  logic       i_stb,
    input  logic [7:0] i_data,
    input  logic       i_rs,
    output logic       o_busy,
    // nybble side
    input  logic       i_nyb_busy,
    output logic       o_nyb_stb,       // one cycle pulse
    output logic [3:0] o_nyb_data,
    output logic       o_nyb_rs
);

    hd44780_pkg::byte_state_t state;
    logic [7:0]               byte_q;       // captured byte
    logic                     rs_q;         // same rs for both halves
    logic                     high_half;    // high nybble on the bus

    // ************************************************************
    // transfer fsm
    // ************************************************************
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state <= hd44780_pkg::BYTE_IDLE;
        end else if (!i_armed) begin
            state <= hd44780_pkg::BYTE_IDLE;
        end else begin
            case (state)
                hd44780_pkg::BYTE_IDLE: begin
                    if (i_stb) begin
                        state <= hd44780_pkg::BYTE_HIGH;
                    end
                end

                hd44780_pkg::BYTE_HIGH: begin
                    // nybble strobe is out this cycle
                    state <= hd44780_pkg::BYTE_WAIT_HIGH;
                end

                hd44780_pkg::BYTE_WAIT_HIGH: begin
                    if (!i_nyb_busy) begin
                        state <= hd44780_pkg::BYTE_LOW;     // strobe low half next cycle
                    end
                end

                hd44780_pkg::BYTE_LOW: begin
                    state <= hd44780_pkg::BYTE_WAIT_LOW;
                end

                hd44780_pkg::BYTE_WAIT_LOW: begin
                    if (!i_nyb_busy) begin
                        state <= hd44780_pkg::BYTE_IDLE;    // busy drops next cycle
                    end
                end

                default: begin
                    state <= hd44780_pkg::BYTE_IDLE;
                end
            endcase
        end
    end

    // payload capture, only taken while idle
    always_ff @(posedge clk) begin
        if (state == hd44780_pkg::BYTE_IDLE && i_stb) begin
            byte_q <= i_data;
            rs_q   <= i_rs;
        end
    end

    // ************************************************************
    // outputs
    // ************************************************************
    assign high_half = (state == hd44780_pkg::BYTE_HIGH) ||
                       (state == hd44780_pkg::BYTE_WAIT_HIGH);

    assign o_busy     = (state != hd44780_pkg::BYTE_IDLE);
    assign o_nyb_stb  = (state == hd44780_pkg::BYTE_HIGH) ||
                        (state == hd44780_pkg::BYTE_LOW);
    assign o_nyb_data = high_half ? byte_q[7:4] : byte_q[3:0];
    assign o_nyb_rs   = rs_q;

endmodule

// File: verilog/hd44780_nybble_sender.sv
// nybble sender
// puts one nybble and rs on the lcd pins and makes the timed enable pulse,
// setup, pulse width and cycle time all counted in clock ticks

`timescale 1ns/10ps

module hd44780_nybble_sender (
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_armed,
    // command side
    input  logic       i_stb,
    input  logic [3:0] i_nybble,
    input  logic       i_rs,
    output logic       o_busy,
    // lcd pins, r/w is tied low on the board
    output logic [3:0] o_lcd_data,
    output logic       o_lcd_rs,
    output logic       o_lcd_e
);

    hd44780_pkg::nyb_state_t                state;
    logic [hd44780_pkg::NYB_COUNT_BITS-1:0] tick;   // one counter for all three phases

    // ************************************************************
    // enable timing fsm
    // ************************************************************
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state      <= hd44780_pkg::NYB_IDLE;
            tick       <= '0;
            o_lcd_e    <= 1'b0;
            o_lcd_rs   <= 1'b0;
            o_lcd_data <= 4'h0;
        end else if (!i_armed) begin
            state   <= hd44780_pkg::NYB_IDLE;
            tick    <= '0;
            o_lcd_e <= 1'b0;
        end else begin
            case (state)
                hd44780_pkg::NYB_IDLE: begin
                    if (i_stb) begin
                        o_lcd_data <= i_nybble;     // pins settle from here on
                        o_lcd_rs   <= i_rs;
                        tick       <= '0;
                        state      <= hd44780_pkg::NYB_SETUP;
                    end
                end

                hd44780_pkg::NYB_SETUP: begin
                    if (tick == hd44780_pkg::TICKS_TAS - 1'b1) begin
                        o_lcd_e <= 1'b1;
                        tick    <= '0;              // count restarts at e rise
                        state   <= hd44780_pkg::NYB_E_HIGH;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end

                hd44780_pkg::NYB_E_HIGH: begin
                    tick <= tick + 1'b1;            // keeps running through e low
                    if (tick == hd44780_pkg::TICKS_PWEH - 1'b1) begin
                        o_lcd_e <= 1'b0;            // lcd latches on this fall
                        state   <= hd44780_pkg::NYB_E_LOW;
                    end
                end

                hd44780_pkg::NYB_E_LOW: begin
                    if (tick == hd44780_pkg::TICKS_TCYCE - 1'b1) begin
                        tick  <= '0;
                        state <= hd44780_pkg::NYB_IDLE;     // data/rs left on the pins
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end

                default: begin
                    o_lcd_e <= 1'b0;
                    state   <= hd44780_pkg::NYB_IDLE;
                end
            endcase
        end
    end

    assign o_busy = (state != hd44780_pkg::NYB_IDLE);

endmodule

// File: verilog/hd44780_top.sv
// top level of the lcd exerciser
// wires the alive block, message sequencer, byte sender and nybble sender to the pins

`timescale 1ns/10ps

module hd44780_top (
    input  logic       clk,
    input  logic       i_arst_n,
    input  logic       i_button_n,      // active low, pulled up on the board
    // lcd
    output logic       o_lcd_rs,
    output logic       o_lcd_e,
    output logic [3:0] o_lcd_data,
    // leds and analyzer trigger
    output logic [3:0] o_led,           // active low
    output logic       o_led_r,
    output logic       o_led_g,
    output logic       o_led_b,
    output logic       o_logan_strobe
);

    logic       armed;
    logic       byte_stb;
    logic [7:0] byte_data;
    logic       byte_rs;
    logic       byte_busy;
    logic       nyb_stb;
    logic [3:0] nyb_data;
    logic       nyb_rs;
    logic       nyb_busy;

    // ************************************************************
    // arming and alive leds
    // ************************************************************
    hd44780_alive alive_inst (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_button_n     (i_button_n),
        .o_armed        (armed),
        .o_logan_strobe (o_logan_strobe),
        .o_led          (o_led),
        .o_led_r        (o_led_r),
        .o_led_g        (o_led_g),
        .o_led_b        (o_led_b)
    );

    // ************************************************************
    // message -> bytes -> nybbles -> pins
    // ************************************************************
    hd44780_msg_seq msg_seq_inst (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_armed     (armed),
        .i_byte_busy (byte_busy),
        .o_byte_stb  (byte_stb),
        .o_byte_data (byte_data),
        .o_byte_rs   (byte_rs)
    );

    hd44780_byte_sender byte_sender_inst (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_armed    (armed),
        .i_stb      (byte_stb),
        .i_data     (byte_data),
        .i_rs       (byte_rs),
        .o_busy     (byte_busy),
        .i_nyb_busy (nyb_busy),
        .o_nyb_stb  (nyb_stb),
        .o_nyb_data (nyb_data),
        .o_nyb_rs   (nyb_rs)
    );

    hd44780_nybble_sender nybble_sender_inst (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_armed    (armed),
        .i_stb      (nyb_stb),
        .i_nybble   (nyb_data),
        .i_rs       (nyb_rs),
        .o_busy     (nyb_busy),
        .o_lcd_data (o_lcd_data),
        .o_lcd_rs   (o_lcd_rs),
        .o_lcd_e    (o_lcd_e)
    );

endmodule

// File: dv/hd44780_tb.sv
// testbench for the hd44780 exerciser top level
// random button presses, an lcd bus model on the enable pin, and checks of the
// enable timing, the captured message, the alive leds and a reset mid-message

`timescale 1ns/10ps

module hd44780_tb;

    // expected behaviour with timing in clock ticks
    localparam int         TAS       = 3;
    localparam int         PWEH      = 22;
    localparam int         TCYCE     = 48;
    localparam int         N_ENTRIES = 4;
    localparam logic [7:0] EXP_BYTE [4] = '{8'h28, 8'h0C, 8'h01, 8'h47};
    localparam logic       EXP_RS   [4] = '{1'b0, 1'b0, 1'b0, 1'b1};

    logic       clk = 1'b0;
    logic       i_arst_n;
    logic       i_button_n;
    logic       o_lcd_rs;
    logic       o_lcd_e;
    logic [3:0] o_lcd_data;
    logic [3:0] o_led;
    logic       o_led_r;
    logic       o_led_g;
    logic       o_led_b;
    logic       o_logan_strobe;

    bit         press_started;      // first low driven on the button
    bit         strobe_seen;        // bus model state from here down
    bit         prev_e;
    bit         have_rise;
    logic [3:0] prev_data;
    logic       prev_rs;
    logic [3:0] rise_data;          // pins as they were at e rise
    logic       rise_rs;
    int         stable_cnt;
    int         high_cnt;
    int         rise_gap;
    int         rst_samples;
    int         pulse_count;
    logic [3:0] cap_data [$];       // one entry per e fall
    logic       cap_rs [$];
    logic [7:0] hist_r = '0;        // last eight rgb samples
    logic [7:0] hist_g = '0;
    logic [7:0] hist_b = '0;
    int         lit_r = 0;          // samples with each rgb led lit
    int         lit_g = 0;
    int         lit_b = 0;
    int         mon_mismatch  = 0;
    int         mon_timing    = 0;
    int         main_mismatch = 0;
    int         main_timeout  = 0;
    int         main_other    = 0;

    always #10 clk = ~clk;  // 20 ns period

    hd44780_top hd44780_top_inst (
        .clk            (clk),
        .i_arst_n       (i_arst_n),
        .i_button_n     (i_button_n),
        .o_lcd_rs       (o_lcd_rs),
        .o_lcd_e        (o_lcd_e),
        .o_lcd_data     (o_lcd_data),
        .o_led          (o_led),
        .o_led_r        (o_led_r),
        .o_led_g        (o_led_g),
        .o_led_b        (o_led_b),
        .o_logan_strobe (o_logan_strobe)
    );

    // returns 1 on a wrong value
    function automatic int check_hex(input string name, input int got, input int expected);
        int bad;
        bad = 0;
        assert (got == expected) else begin
            $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, expected);
            bad = 1;
        end
        return bad;
    endfunction

    // ************************************************************
    // lcd bus model sampled on the rising edge
    // ************************************************************
    always @(posedge clk) begin
        if (!i_arst_n) begin
            if (rst_samples > 0) begin      // very first sample can predate the reset
                mon_mismatch += check_hex("o_lcd_e", int'(o_lcd_e), 0);
                mon_mismatch += check_hex("o_lcd_rs", int'(o_lcd_rs), 0);
                mon_mismatch += check_hex("o_lcd_data", int'(o_lcd_data), 0);
                mon_mismatch += check_hex("o_logan_strobe", int'(o_logan_strobe), 0);
                mon_mismatch += check_hex("o_led", int'(o_led), 15);
            end
            rst_samples++;
            strobe_seen = 1'b0;
            have_rise   = 1'b0;
            stable_cnt  = 0;
            pulse_count = 0;
            cap_data.delete();
            cap_rs.delete();
        end else begin
            rst_samples = 0;
            if (!press_started) begin       // idle until armed
                mon_mismatch += check_hex("o_lcd_e", int'(o_lcd_e), 0);
                mon_mismatch += check_hex("o_logan_strobe", int'(o_logan_strobe), 0);
                mon_mismatch += check_hex("o_led", int'(o_led), 15);
            end
            if (strobe_seen) begin
                assert (o_logan_strobe) else begin
                    $display("analyzer strobe dropped after arming without a reset");
                    mon_timing++;
                end
            end
            if (o_logan_strobe) begin
                strobe_seen = 1'b1;
            end

            if (o_lcd_data == prev_data && o_lcd_rs == prev_rs) begin
                stable_cnt++;
            end else begin
                stable_cnt = 0;
            end
            rise_gap++;

            if (o_lcd_e && !prev_e) begin               // e rise
                assert (stable_cnt >= TAS) else begin
                    $display("data/rs stable only %0d cycles before e rose", stable_cnt);
                    mon_timing++;
                end
                if (have_rise) begin
                    assert (rise_gap >= TCYCE) else begin
                        $display("e rose only %0d cycles after the previous rise", rise_gap);
                        mon_timing++;
                    end
                end
                have_rise = 1'b1;
                rise_gap  = 0;
                high_cnt  = 1;
                rise_data = o_lcd_data;
                rise_rs   = o_lcd_rs;
            end else if (o_lcd_e && prev_e) begin       // e still high
                high_cnt++;
                mon_mismatch += check_hex("o_lcd_data", int'(o_lcd_data), int'(rise_data));
                mon_mismatch += check_hex("o_lcd_rs", int'(o_lcd_rs), int'(rise_rs));
            end else if (!o_lcd_e && prev_e) begin      // e fall where the lcd latches
                mon_mismatch += check_hex("o_lcd_e high width", high_cnt, PWEH);
                mon_mismatch += check_hex("o_lcd_data", int'(o_lcd_data), int'(rise_data));
                mon_mismatch += check_hex("o_lcd_rs", int'(o_lcd_rs), int'(rise_rs));
                cap_data.push_back(o_lcd_data);
                cap_rs.push_back(o_lcd_rs);
                pulse_count++;
            end
        end
        prev_e    = o_lcd_e;
        prev_data = o_lcd_data;
        prev_rs   = o_lcd_rs;

        // dimmed rgb is lit at most once in any eight samples
        hist_r = {hist_r[6:0], o_led_r};
        hist_g = {hist_g[6:0], o_led_g};
        hist_b = {hist_b[6:0], o_led_b};
        assert ($countones(hist_r) <= 1 && $countones(hist_g) <= 1 &&
                $countones(hist_b) <= 1) else begin
            $display("rgb led lit more than once in eight cycles (r %b g %b b %b)",
                     hist_r, hist_g, hist_b);
            mon_timing++;
        end
        if (o_led_r) begin
            lit_r++;
        end
        if (o_led_g) begin
            lit_g++;
        end
        if (o_led_b) begin
            lit_b++;
        end
    end

    // ************************************************************
    // stimulus tasks drive on the falling edge
    // ************************************************************
    task automatic apply_reset();
        @(negedge clk);
        i_arst_n      = 1'b0;
        i_button_n    = 1'b1;
        press_started = 1'b0;
        repeat (10) @(negedge clk);
        i_arst_n = 1'b1;
    endtask

    // idle, a few short glitches, then a held press
    task automatic press_button();
        int idle_cycles;
        int n_glitch;
        int g;
        idle_cycles = 20 + $urandom % 281;
        n_glitch    = 1 + $urandom % 3;
        repeat (idle_cycles) @(negedge clk);
        for (g = 0; g < n_glitch; g++) begin
            i_button_n    = 1'b0;
            press_started = 1'b1;
            repeat (1 + $urandom % 3) @(negedge clk);
            i_button_n = 1'b1;
            repeat (1 + $urandom % 5) @(negedge clk);
        end
        i_button_n = 1'b0;
        repeat (30) @(negedge clk);
        i_button_n = 1'b1;
    endtask

    // strobe up, then the external leds start blinking
    task automatic check_armed();
        int cycles;
        cycles = 0;
        while (o_logan_strobe !== 1'b1 && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        assert (o_logan_strobe === 1'b1) else begin
            $display("timeout, analyzer strobe never went high after the press");
            main_timeout++;
        end
        cycles = 0;
        while (o_led === 4'hF && cycles < 260) begin     // 2^8 plus margin
            @(negedge clk);
            cycles++;
        end
        assert (o_led !== 4'hF) else begin
            $display("timeout, external leds never left the off state after arming");
            main_timeout++;
        end
    endtask

    task automatic wait_pulses(input int count, input int limit);
        int cycles;
        cycles = 0;
        while (pulse_count < count && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (pulse_count >= count) else begin
            $display("timeout waiting for %0d e pulses, saw %0d", count, pulse_count);
            main_timeout++;
        end
    endtask

    task automatic wait_e_high(input int limit);
        int cycles;
        cycles = 0;
        while (o_lcd_e !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        assert (o_lcd_e === 1'b1) else begin
            $display("timeout waiting for e to go high");
            main_timeout++;
        end
    endtask

    // high then low nybble per entry, then the bus must stay quiet
    task automatic check_message();
        int         i;
        logic [3:0] exp_nyb;
        wait_pulses(2 * N_ENTRIES, 3000);
        for (i = 0; i < 2 * N_ENTRIES && i < cap_data.size(); i++) begin
            exp_nyb = (i % 2 == 0) ? EXP_BYTE[i / 2][7:4] : EXP_BYTE[i / 2][3:0];
            main_mismatch += check_hex("o_lcd_data", int'(cap_data[i]), int'(exp_nyb));
            main_mismatch += check_hex("o_lcd_rs", int'(cap_rs[i]), int'(EXP_RS[i / 2]));
        end
        repeat (4 * TCYCE) @(negedge clk);
        main_mismatch += check_hex("e pulse count", pulse_count, 2 * N_ENTRIES);
    endtask

    // every rgb led must have lit at some point of the run
    task automatic check_rgb_lit();
        assert (lit_r > 0 && lit_g > 0 && lit_b > 0) else begin
            $display("an rgb led was never lit (r %0d g %0d b %0d samples)",
                     lit_r, lit_g, lit_b);
            main_other++;
        end
    endtask

    // ************************************************************
    // main sequence
    // ************************************************************
    initial begin
        i_arst_n      = 1'b0;
        i_button_n    = 1'b1;
        press_started = 1'b0;
        void'($urandom(32'h6b7));

        apply_reset();              // full message once
        press_button();
        check_armed();
        check_message();

        apply_reset();              // cut it short in the data write
        press_button();
        check_armed();
        wait_pulses(6, 2000);
        wait_e_high(200);           // e, rs and data all nonzero here
        apply_reset();              // pins checked by the bus model while held

        press_button();             // replay from entry 0
        check_armed();
        check_message();
        check_rgb_lit();

        $display("errors: %0d mismatch, %0d timing, %0d timeout, %0d other",
                 mon_mismatch + main_mismatch, mon_timing, main_timeout, main_other);
        if (mon_mismatch + main_mismatch + mon_timing + main_timeout + main_other == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/hd44780_pkg.sv
verilog/hd44780_alive.sv
verilog/hd44780_msg_seq.sv
verilog/hd44780_byte_sender.sv
verilog/hd44780_nybble_sender.sv
verilog/hd44780_top.sv
dv/hd44780_tb.sv

// File: Makefile
# verilator build and run of the hd44780 testbench
TOP := hd44780_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log
